/* verilog/jtframe_sdram_defines.svh */
// bus widths, slot count and slot geometries for the sdram request side

`ifndef JTFRAME_SDRAM_DEFINES_SVH
`define JTFRAME_SDRAM_DEFINES_SVH

////////////////////
// external bus
`define SDRAM_AW    22      // halfword address
`define SDRAM_DW    32      // read return, addressed halfword plus the next one
`define SDRAM_NSLOT 3       // arbiter inputs

////////////////////
// slot geometries, address and data widths
`define SLOT0_AW    18      // rom, 16-bit data
`define SLOT0_DW    16
`define SLOT1_AW    17      // rom, 8-bit data
`define SLOT1_DW    8
`define SLOT2_AW    13      // ram, 8-bit data
`define SLOT2_DW    8

`endif

/* verilog/jtframe_sdram_slot_if.sv */
// interface: one slot's request and return signals, slot and arbiter modports
`timescale 1ns/100ps

`include "jtframe_sdram_defines.svh"

interface jtframe_sdram_slot_if;

    ////////////////////
    // slot to arbiter
    logic                 req;          // held until we
    logic                 req_rnw;      // 1 = read
    logic [`SDRAM_AW-1:0] sdram_addr;   // stable while req is high
    logic [15:0]          wrdata;       // byte lane duplicated on 8-bit slots
    logic [1:0]           wrmask;       // byte enable, active high

    ////////////////////
    // arbiter to slot
    logic                 we;           // request accepted, one cycle
    logic [`SDRAM_DW-1:0] din;          // registered read word
    logic                 din_ok;       // read data valid or write done

    modport slot (
        output req, req_rnw, sdram_addr, wrdata, wrmask,
        input  we, din, din_ok
    );

    modport arb (
        input  req, req_rnw, sdram_addr, wrdata, wrmask,
        output we, din, din_ok
    );

endinterface

/* verilog/jtframe_sdram_pkg.sv */
// package: returned sdram word union and slot type enumeration

`include "jtframe_sdram_defines.svh"

package jtframe_sdram_pkg;

    // one read return, seen as halves or as bytes
    // halves[0] and bytes[1:0] hold the addressed halfword
    typedef union packed {
        logic [1:0][`SDRAM_DW/2-1:0] halves;
        logic [3:0][7:0]             bytes;
    } sdram_word_u;

    // slot behaviour selected in the wrapper
    typedef enum logic [1:0] {
        ROM    = 2'd0,  // read only, one word cache
        WRONLY = 2'd1,  // write only, not built here
        RW     = 2'd2   // read/write pass through
    } slot_type_e;

endpackage

/* verilog/jtframe_romrq.sv */
// read-only slot logic with one word cache, hit detection, half and byte select
`timescale 1ns/100ps

`include "jtframe_sdram_defines.svh"

module jtframe_romrq import jtframe_sdram_pkg::*; #(
    parameter int AW = 18,
    parameter int DW = 8
)(
    input  logic                 rst,
    input  logic                 clk,
    input  logic                 cen,
    input  logic [AW-1:0]        addr,
    input  logic [`SDRAM_AW-1:0] sdram_addr_in,   // halfword address with offset added
    input  logic                 byte_sel,        // only meaningful for 8-bit slots
    input  logic                 addr_ok,
    jtframe_sdram_slot_if.slot   bus,
    output logic [DW-1:0]        dout,
    output logic                 data_ok          // level held while addr is stable
);

sdram_word_u          cache;        // last word fetched
logic [`SDRAM_AW-1:0] base;         // halfword address of cache.halves[0]
logic [`SDRAM_AW-1:0] req_addr;     // address of the pending miss
logic [AW-1:0]        addr_l;       // client address that data_ok refers to
logic                 valid;
logic                 req;
logic                 wait_fill;    // accepted and waiting for din_ok
logic                 recheck;      // cache just filled so look again without cen
logic                 hit_lo, hit_hi, hit;
logic                 busy, sample;
logic [DW-1:0]        sel;

assign hit_lo = valid && sdram_addr_in == base;
// second half of the word
assign hit_hi = valid && sdram_addr_in == base + {{(`SDRAM_AW-1){1'b0}}, 1'b1};
assign hit    = hit_lo || hit_hi;
assign busy   = req || wait_fill;
// new lookup once the previous result has been dropped
assign sample = addr_ok && !data_ok && !busy && (cen || recheck);

generate
    if (DW == 8) begin : g_byte
        assign sel = cache.bytes[{!hit_lo, byte_sel}];    // half then byte
    end else begin : g_half
        assign sel = cache.halves[!hit_lo];
    end
endgenerate

assign bus.req        = req;
assign bus.sdram_addr = req_addr;

////////////////////
// control
always_ff @(posedge clk) begin
    if (rst) begin
        req       <= 1'b0;
        wait_fill <= 1'b0;
        recheck   <= 1'b0;
        valid     <= 1'b0;      // cache starts empty
        data_ok   <= 1'b0;
    end else begin
        recheck <= 1'b0;
        if (bus.we) begin
            req       <= 1'b0;
            wait_fill <= 1'b1;
        end
        if (bus.din_ok) begin
            valid     <= 1'b1;
            wait_fill <= 1'b0;
            recheck   <= 1'b1;  // data_ok one edge after the fill
        end
        if (!addr_ok || addr != addr_l)
            data_ok <= 1'b0;    // client moved on
        if (sample) begin
            if (hit)
                data_ok <= 1'b1;
            else
                req <= 1'b1;    // miss goes to the bus
        end
    end
end

////////////////////
// cache and result registers
always_ff @(posedge clk) begin
    if (sample) begin
        addr_l <= addr;
        if (hit)
            dout <= sel;
        else
            req_addr <= sdram_addr_in;
    end
    if (bus.din_ok) begin
        cache <= bus.din;
        base  <= req_addr;      // word starts at the missed halfword
    end
end

endmodule

/* verilog/jtframe_ram_rq.sv */
// read/write slot logic with one bus access per addr_ok rising edge and a data_ok pulse
`timescale 1ns/100ps

`include "jtframe_sdram_defines.svh"

module jtframe_ram_rq import jtframe_sdram_pkg::*; #(
    parameter int DW = 8
)(
    input  logic                 rst,
    input  logic                 clk,
    input  logic                 cen,
    input  logic [`SDRAM_AW-1:0] sdram_addr_in,
    input  logic                 byte_sel,
    input  logic                 addr_ok,     // must toggle for each access
    input  logic                 wrin,        // 1 = write
    input  logic [DW-1:0]        wrdata,
    jtframe_sdram_slot_if.slot   bus,
    output logic [DW-1:0]        dout,
    output logic                 data_ok      // one cycle on reads and writes
);

sdram_word_u          rdword;
logic                 addr_ok_l;    // addr_ok as seen on the last cen
logic                 req;
logic                 pend;         // access in flight
logic                 start;
logic                 rnw;
logic                 sel_l;        // byte lane of the pending read
logic [`SDRAM_AW-1:0] addr_r;
logic [15:0]          wr_word, wrdata_r;
logic [1:0]           wr_mask, wrmask_r;
logic [DW-1:0]        rd_sel;

assign start  = cen && addr_ok && !addr_ok_l && !pend;    // rising edge only
assign rdword = bus.din;

generate
    if (DW == 8) begin : g_byte
        assign wr_word = {2{wrdata}};                       // same byte on both lanes
        assign wr_mask = byte_sel ? 2'b10 : 2'b01;
        assign rd_sel  = rdword.bytes[{1'b0, sel_l}];       // within halves[0]
    end else begin : g_half
        assign wr_word = wrdata;
        assign wr_mask = 2'b11;
        assign rd_sel  = rdword.halves[0];
    end
endgenerate

assign bus.req        = req;
assign bus.req_rnw    = rnw;
assign bus.sdram_addr = addr_r;
assign bus.wrdata     = wrdata_r;
assign bus.wrmask     = wrmask_r;

////////////////////
// control
always_ff @(posedge clk) begin
    if (rst) begin
        addr_ok_l <= 1'b0;
        req       <= 1'b0;
        pend      <= 1'b0;
        data_ok   <= 1'b0;
    end else begin
        data_ok <= 1'b0;
        if (cen)
            addr_ok_l <= addr_ok;
        if (start) begin
            req  <= 1'b1;
            pend <= 1'b1;
        end
        if (bus.we)
            req <= 1'b0;        // accepted so wait for din_ok
        if (bus.din_ok) begin
            pend    <= 1'b0;
            data_ok <= 1'b1;
        end
    end
end

////////////////////
// access and read data
always_ff @(posedge clk) begin
    if (start) begin
        rnw      <= !wrin;
        addr_r   <= sdram_addr_in;
        wrdata_r <= wr_word;
        wrmask_r <= wr_mask;
        sel_l    <= byte_sel;
    end
    if (bus.din_ok && rnw)
        dout <= rd_sel;         // kept until the next read
end

endmodule

/* verilog/jtframe_sdram_rq.sv */
// slot wrapper: rom or ram logic by TYPE, slot to sdram address mapping
`timescale 1ns/100ps

`include "jtframe_sdram_defines.svh"

module jtframe_sdram_rq import jtframe_sdram_pkg::*; #(
    parameter int         AW   = 18,
    parameter int         DW   = 8,
    parameter slot_type_e TYPE = ROM
)(
    input  logic                 rst,
    input  logic                 clk,
    input  logic                 cen,
    input  logic [AW-1:0]        addr,
    input  logic [`SDRAM_AW-1:0] offset,    // fixed during a run
    input  logic                 addr_ok,
    input  logic                 wrin,
    input  logic [DW-1:0]        wrdata,
    output logic [DW-1:0]        dout,
    output logic                 data_ok,
    jtframe_sdram_slot_if.slot   bus
);

localparam int HW = (DW == 8) ? AW - 1 : AW;   // halfword address bits

logic [HW-1:0]        hw_addr;
logic                 byte_sel;
logic [`SDRAM_AW-1:0] sdram_addr_in;

////////////////////
// address mapping
generate
    if (DW == 8) begin : g_byte
        assign hw_addr  = addr[AW-1:1];
        assign byte_sel = addr[0];      // 0 = low byte of the halfword
    end else begin : g_half
        assign hw_addr  = addr;
        assign byte_sel = 1'b0;
    end
endgenerate

assign sdram_addr_in = offset + {{(`SDRAM_AW-HW){1'b0}}, hw_addr};

////////////////////
// slot logic
generate
    if (TYPE == RW) begin : g_rw
        jtframe_ram_rq #(.DW(DW)) u_rw (
            .rst           ( rst           ),
            .clk           ( clk           ),
            .cen           ( cen           ),
            .sdram_addr_in ( sdram_addr_in ),
            .byte_sel      ( byte_sel      ),
            .addr_ok       ( addr_ok       ),
            .wrin          ( wrin          ),
            .wrdata        ( wrdata        ),
            .bus           ( bus           ),
            .dout          ( dout          ),
            .data_ok       ( data_ok       )
        );
    end else begin : g_ro    // any other type is built as read only
        assign bus.req_rnw = 1'b1;
        assign bus.wrdata  = '0;
        assign bus.wrmask  = '0;

        jtframe_romrq #(.AW(AW), .DW(DW)) u_ro (
            .rst           ( rst           ),
            .clk           ( clk           ),
            .cen           ( cen           ),
            .addr          ( addr          ),
            .sdram_addr_in ( sdram_addr_in ),
            .byte_sel      ( byte_sel      ),
            .addr_ok       ( addr_ok       ),
            .bus           ( bus           ),
            .dout          ( dout          ),
            .data_ok       ( data_ok       )
        );
    end
endgenerate

endmodule

/* verilog/jtframe_sdram_arb.sv */
// fixed-priority arbiter: external command strobes and read data routing
`timescale 1ns/100ps

`include "jtframe_sdram_defines.svh"

module jtframe_sdram_arb (
    input  logic                 rst,
    input  logic                 clk,
    input  logic [`SDRAM_DW-1:0] sd_rdata,
    input  logic                 sd_rdy,    // ends the current command
    jtframe_sdram_slot_if.arb    slot0,     // highest priority
    jtframe_sdram_slot_if.arb    slot1,
    jtframe_sdram_slot_if.arb    slot2,
    output logic [`SDRAM_AW-1:0] sd_addr,
    output logic                 sd_rd,
    output logic                 sd_wr,
    output logic [15:0]          sd_wrdata,
    output logic [1:0]           sd_dsn     // active low, zero on reads
);

localparam int NS = `SDRAM_NSLOT;   // three modports below
localparam int IW = $clog2(NS);

logic [NS-1:0]        req_v, rnw_v;
logic [`SDRAM_AW-1:0] addr_v   [NS];
logic [15:0]          wrdata_v [NS];
logic [1:0]           mask_v   [NS];
logic [NS-1:0]        we_r, din_ok_r;
logic [`SDRAM_DW-1:0] din_r;
logic [IW-1:0]        owner, gnt;
logic                 busy;         // one command in flight
logic                 grant;

////////////////////
// gather the slots
assign req_v = {slot2.req, slot1.req, slot0.req};
assign rnw_v = {slot2.req_rnw, slot1.req_rnw, slot0.req_rnw};

assign addr_v[0]   = slot0.sdram_addr;
assign addr_v[1]   = slot1.sdram_addr;
assign addr_v[2]   = slot2.sdram_addr;
assign wrdata_v[0] = slot0.wrdata;
assign wrdata_v[1] = slot1.wrdata;
assign wrdata_v[2] = slot2.wrdata;
assign mask_v[0]   = slot0.wrmask;
assign mask_v[1]   = slot1.wrmask;
assign mask_v[2]   = slot2.wrmask;

// lowest requesting index wins
always_comb begin
    gnt = '0;
    for (int i = NS - 1; i >= 0; i--) begin
        if (req_v[i])
            gnt = IW'(i);
    end
end

assign grant = !busy && |req_v;

////////////////////
// command and ownership
always_ff @(posedge clk) begin
    if (rst) begin
        busy     <= 1'b0;
        owner    <= '0;
        we_r     <= '0;
        din_ok_r <= '0;
        sd_rd    <= 1'b0;
        sd_wr    <= 1'b0;
    end else begin
        we_r     <= '0;         // all strobes are single cycle
        din_ok_r <= '0;
        sd_rd    <= 1'b0;
        sd_wr    <= 1'b0;
        if (grant) begin
            busy       <= 1'b1;
            owner      <= gnt;
            we_r[gnt]  <= 1'b1;
            sd_rd      <= rnw_v[gnt];
            sd_wr      <= !rnw_v[gnt];
        end
        if (busy && sd_rdy) begin
            busy            <= 1'b0;
            din_ok_r[owner] <= 1'b1;    // only the owner hears about it
        end
    end
end

always_ff @(posedge clk) begin
    if (grant) begin
        sd_addr   <= addr_v[gnt];
        sd_wrdata <= wrdata_v[gnt];
        sd_dsn    <= rnw_v[gnt] ? 2'b00 : ~mask_v[gnt];
    end
    if (busy && sd_rdy)
        din_r <= sd_rdata;
end

////////////////////
// back to the slots
assign slot0.we     = we_r[0];
assign slot1.we     = we_r[1];
assign slot2.we     = we_r[2];
assign slot0.din    = din_r;
assign slot1.din    = din_r;
assign slot2.din    = din_r;
assign slot0.din_ok = din_ok_r[0];
assign slot1.din_ok = din_ok_r[1];
assign slot2.din_ok = din_ok_r[2];

endmodule

/* verilog/jtframe_sdram_sub.sv */
// top level: two rom slots, one ram slot and the bus arbiter
`timescale 1ns/100ps

`include "jtframe_sdram_defines.svh"

module jtframe_sdram_sub import jtframe_sdram_pkg::*; (
    input  logic                  rst,
    input  logic                  clk,
    input  logic                  cen,
    // slot 0, rom 16-bit
    input  logic [`SLOT0_AW-1:0]  addr0,
    input  logic [`SDRAM_AW-1:0]  offset0,
    input  logic                  addr_ok0,
    output logic [`SLOT0_DW-1:0]  dout0,
    output logic                  data_ok0,
    // slot 1, rom 8-bit
    input  logic [`SLOT1_AW-1:0]  addr1,
    input  logic [`SDRAM_AW-1:0]  offset1,
    input  logic                  addr_ok1,
    output logic [`SLOT1_DW-1:0]  dout1,
    output logic                  data_ok1,
    // slot 2, ram 8-bit
    input  logic [`SLOT2_AW-1:0]  addr2,
    input  logic [`SDRAM_AW-1:0]  offset2,
    input  logic                  addr_ok2,
    input  logic                  wrin2,
    input  logic [`SLOT2_DW-1:0]  wrdata2,
    output logic [`SLOT2_DW-1:0]  dout2,
    output logic                  data_ok2,
    // external bus
    input  logic [`SDRAM_DW-1:0]  sd_rdata,
    input  logic                  sd_rdy,
    output logic [`SDRAM_AW-1:0]  sd_addr,
    output logic                  sd_rd,
    output logic                  sd_wr,
    output logic [15:0]           sd_wrdata,
    output logic [1:0]            sd_dsn
);

jtframe_sdram_slot_if slot0_if ();
jtframe_sdram_slot_if slot1_if ();
jtframe_sdram_slot_if slot2_if ();

jtframe_sdram_rq #(.AW(`SLOT0_AW), .DW(`SLOT0_DW), .TYPE(ROM)) u_slot0 (
    .rst     ( rst      ),
    .clk     ( clk      ),
    .cen     ( cen      ),
    .addr    ( addr0    ),
    .offset  ( offset0  ),
    .addr_ok ( addr_ok0 ),
    .wrin    ( 1'b0     ),      // rom, never written
    .wrdata  ( '0       ),
    .dout    ( dout0    ),
    .data_ok ( data_ok0 ),
    .bus     ( slot0_if )
);

jtframe_sdram_rq #(.AW(`SLOT1_AW), .DW(`SLOT1_DW), .TYPE(ROM)) u_slot1 (
    .rst     ( rst      ),
    .clk     ( clk      ),
    .cen     ( cen      ),
    .addr    ( addr1    ),
    .offset  ( offset1  ),
    .addr_ok ( addr_ok1 ),
    .wrin    ( 1'b0     ),
    .wrdata  ( '0       ),
    .dout    ( dout1    ),
    .data_ok ( data_ok1 ),
    .bus     ( slot1_if )
);

jtframe_sdram_rq #(.AW(`SLOT2_AW), .DW(`SLOT2_DW), .TYPE(RW)) u_slot2 (
    .rst     ( rst      ),
    .clk     ( clk      ),
    .cen     ( cen      ),
    .addr    ( addr2    ),
    .offset  ( offset2  ),
    .addr_ok ( addr_ok2 ),
    .wrin    ( wrin2    ),
    .wrdata  ( wrdata2  ),
    .dout    ( dout2    ),
    .data_ok ( data_ok2 ),
    .bus     ( slot2_if )
);

jtframe_sdram_arb u_arb (
    .rst       ( rst       ),
    .clk       ( clk       ),
    .sd_rdata  ( sd_rdata  ),
    .sd_rdy    ( sd_rdy    ),
    .slot0     ( slot0_if  ),
    .slot1     ( slot1_if  ),
    .slot2     ( slot2_if  ),
    .sd_addr   ( sd_addr   ),
    .sd_rd     ( sd_rd     ),
    .sd_wr     ( sd_wr     ),
    .sd_wrdata ( sd_wrdata ),
    .sd_dsn    ( sd_dsn    )
);

endmodule

/* verif/jtframe_sdram_tb.sv */
// testbench with clock, reset, sdram memory model, random client traffic and checks
`timescale 1ns/100ps

`include "jtframe_sdram_defines.svh"

module jtframe_sdram_tb import jtframe_sdram_pkg::*;;

localparam logic [21:0] OFF0 = 22'h010000;   // slot regions in the sdram
localparam logic [21:0] OFF1 = 22'h020000;
localparam logic [21:0] OFF2 = 22'h030000;
localparam int N_RD0   = 40;                  // operations per test
localparam int N_GRP   = 10;
localparam int N_WR    = 20;
localparam int N_BURST = 8;
localparam int N_CEN   = 4;
localparam int N_OPS   = N_RD0 + 4 * N_GRP + 3 * N_WR + 3 * N_BURST + 2 * N_CEN;
localparam int TIMEOUT_NS = (N_OPS * 12 + 2000) * 40;   // 12 cycles per op plus margin

logic                 rst, clk, cen;
logic [`SLOT0_AW-1:0] addr0;
logic [`SLOT1_AW-1:0] addr1;
logic [`SLOT2_AW-1:0] addr2;
logic [`SDRAM_AW-1:0] offset0, offset1, offset2;
logic                 addr_ok0, addr_ok1, addr_ok2, wrin2;
logic [`SLOT2_DW-1:0] wrdata2;
logic [`SLOT0_DW-1:0] dout0;
logic [`SLOT1_DW-1:0] dout1;
logic [`SLOT2_DW-1:0] dout2;
logic                 data_ok0, data_ok1, data_ok2;
logic [`SDRAM_DW-1:0] sd_rdata;
logic                 sd_rdy, sd_rd, sd_wr;
logic [`SDRAM_AW-1:0] sd_addr;
logic [15:0]          sd_wrdata;
logic [1:0]           sd_dsn;

integer      seed = 28;
logic [15:0] mem [logic [21:0]];     // halfword memory used as the reference model
logic [21:0] cmd_q [$];              // addresses of bus commands in order
int unsigned rd_cnt = 0, wr_cnt = 0;
int unsigned checks = 0, errors = 0;
logic [21:0] c_base [2];             // expected rom cache base of slots 0 and 1
bit          c_valid [2];

logic [17:0] a0;
logic [16:0] a1;
logic [12:0] a2;
logic [7:0]  d, q, nb;
logic [21:0] hw;
int unsigned c0, e0, n0;

jtframe_sdram_sub dut0 (.*);

initial begin : clock_gen
    clk = 1'b0;
    forever #20 clk = ~clk;      // 40 ns period
end

////////////////////
// helpers
function automatic int unsigned rnd(input int unsigned m);
    return $unsigned($random(seed)) % m;
endfunction

function automatic logic [15:0] mem_hw(input logic [21:0] a);
    if (mem.exists(a))
        return mem[a];
    return a[15:0] ^ {a[21:16], 10'h0};      // area never loaded
endfunction

function automatic logic [7:0] mem_byte(input logic [21:0] a, input bit sel);
    sdram_word_u w;
    w = '0;
    w.halves[0] = mem_hw(a);
    return w.bytes[{1'b0, sel}];             // sel 0 is the low byte
endfunction

// a read here goes to the bus only if the cached word misses it
function automatic bit covered(input int s, input logic [21:0] a);
    return c_valid[s] && (a == c_base[s] || a == c_base[s] + 22'd1);
endfunction

task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
    end
endtask

task automatic report_test(input string name, input int unsigned c, input int unsigned e);
    $display("test %s: %0d checks, %0d errors", name, checks - c, errors - e);
endtask

////////////////////
// client side
task automatic rom0_read(input logic [17:0] a, input bit solo);
    logic [21:0] h;
    int unsigned rd0;
    bit          miss;
    h    = OFF0 + 22'(a);
    miss = !covered(0, h);
    rd0  = rd_cnt;
    @(negedge clk);
    addr0    = a;
    addr_ok0 = 1'b1;
    while (!data_ok0) @(negedge clk);
    check(32'(dout0), 32'(mem_hw(h)), "slot 0 halfword");
    if (solo)
        check(rd_cnt - rd0, 32'(miss), "slot 0 bus reads");
    if (miss) begin
        c_base[0]  = h;      // word now starts at the missed halfword
        c_valid[0] = 1'b1;
    end
    addr_ok0 = 1'b0;
    @(negedge clk);          // data_ok0 drops here
endtask

task automatic rom1_read(input logic [16:0] a, input bit solo);
    logic [21:0] h;
    int unsigned rd0;
    bit          miss;
    h    = OFF1 + 22'(a[16:1]);
    miss = !covered(1, h);
    rd0  = rd_cnt;
    @(negedge clk);
    addr1    = a;
    addr_ok1 = 1'b1;
    while (!data_ok1) @(negedge clk);
    check(32'(dout1), 32'(mem_byte(h, a[0])), "slot 1 byte");
    if (solo)
        check(rd_cnt - rd0, 32'(miss), "slot 1 bus reads");
    if (miss) begin
        c_base[1]  = h;
        c_valid[1] = 1'b1;
    end
    addr_ok1 = 1'b0;
    @(negedge clk);
endtask

// one access per addr_ok2 pulse with the read value returned in rd
task automatic ram_access(input logic [12:0] a, input bit wr, input logic [7:0] wd,
                          output logic [7:0] rd);
    logic [21:0] h;
    h = OFF2 + 22'(a[12:1]);
    @(negedge clk);
    addr2    = a;
    wrin2    = wr;
    wrdata2  = wd;
    addr_ok2 = 1'b1;
    while (!data_ok2) @(negedge clk);    // single cycle pulse
    rd = dout2;
    if (!wr)
        check(32'(dout2), 32'(mem_byte(h, a[0])), "slot 2 read");
    addr_ok2 = 1'b0;
    @(negedge clk);          // slot sees addr_ok2 low before the next access
endtask

////////////////////
// sdram model serving one command at a time
initial begin : mem_model
    logic [21:0] a;
    logic [15:0] w;
    int unsigned lat;
    sdram_word_u rword;
    forever begin
        @(negedge clk);
        if (!rst && (sd_rd || sd_wr)) begin
            a = sd_addr;
            if (sd_wr) begin
                w = mem_hw(a);
                if (!sd_dsn[0]) w[7:0]  = sd_wrdata[7:0];    // lanes active low
                if (!sd_dsn[1]) w[15:8] = sd_wrdata[15:8];
                mem[a] = w;
            end
            rword.halves[0] = mem_hw(a);
            rword.halves[1] = mem_hw(a + 22'd1);
            lat = 2 + rnd(8);                // 2 to 9 cycles
            repeat (lat) @(negedge clk);
            sd_rdata = rword;
            sd_rdy   = 1'b1;
            @(negedge clk);
            sd_rdy   = 1'b0;
        end
    end
end

// bus command monitor
always @(negedge clk) begin
    if (sd_rd) rd_cnt <= rd_cnt + 1;
    if (sd_wr) wr_cnt <= wr_cnt + 1;
    if (sd_rd || sd_wr) cmd_q.push_back(sd_addr);
end

initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Testbench failed");
    $finish;
end

////////////////////
// tests
initial begin : stimulus
    rst = 1'b1;
    cen = 1'b1;
    addr0 = '0;
    addr1 = '0;
    addr2 = '0;
    addr_ok0 = 1'b0;
    addr_ok1 = 1'b0;
    addr_ok2 = 1'b0;
    wrin2 = 1'b0;
    wrdata2 = '0;
    offset0 = OFF0;      // fixed for the run
    offset1 = OFF1;
    offset2 = OFF2;
    sd_rdata = '0;
    sd_rdy = 1'b0;
    c_valid[0] = 1'b0;
    c_valid[1] = 1'b0;
    for (int i = 0; i < 1026; i++) begin
        mem[OFF0 + 22'(i)] = 16'($random(seed));
        mem[OFF1 + 22'(i)] = 16'($random(seed));
        mem[OFF2 + 22'(i)] = 16'($random(seed));
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_RD0; i++)
        rom0_read(18'(rnd(1024)), 1'b1);
    report_test("1 rom slot 0 random reads", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_GRP; i++) begin
        a1 = 17'(rnd(256) * 4);                  // four bytes in a row
        for (int k = 0; k < 4; k++)
            rom1_read(a1 + 17'(k), 1'b1);
    end
    report_test("2 rom slot 1 byte reads", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_WR; i++) begin
        a2 = 13'(rnd(1024));
        d  = 8'(rnd(256));
        hw = OFF2 + 22'(a2[12:1]);
        nb = mem_byte(hw, !a2[0]);               // other byte of the halfword
        ram_access(a2, 1'b1, d, q);
        check(32'(mem_byte(hw, a2[0])), 32'(d), "slot 2 written byte in memory");
        check(32'(mem_byte(hw, !a2[0])), 32'(nb), "slot 2 neighbour byte in memory");
        ram_access(a2, 1'b0, 8'h00, q);
        check(32'(q), 32'(d), "slot 2 readback");
        ram_access(a2 ^ 13'd1, 1'b0, 8'h00, q);
        check(32'(q), 32'(nb), "slot 2 neighbour readback");
    end
    report_test("3 ram slot writes and reads", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_BURST; i++) begin
        do a0 = 18'(rnd(1024)); while (covered(0, OFF0 + 22'(a0)));
        do a1 = 17'(rnd(1024)); while (covered(1, OFF1 + 22'(a1[16:1])));
        a2 = 13'(rnd(1024));
        cmd_q.delete();
        fork                                     // same falling edge for all three
            rom0_read(a0, 1'b0);
            rom1_read(a1, 1'b0);
            ram_access(a2, 1'b0, 8'h00, q);
        join
        check(32'(cmd_q.size()), 32'd3, "bus commands in burst");
        if (cmd_q.size() == 3) begin
            check(32'(cmd_q[0]), 32'(OFF0 + 22'(a0)), "first command from slot 0");
            check(32'(cmd_q[1]), 32'(OFF1 + 22'(a1[16:1])), "second command from slot 1");
            check(32'(cmd_q[2]), 32'(OFF2 + 22'(a2[12:1])), "third command from slot 2");
        end
    end
    report_test("4 three slot contention", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_CEN; i++) begin
        do a0 = 18'(rnd(1024)); while (covered(0, OFF0 + 22'(a0)));
        a2 = 13'(rnd(1024));
        n0 = rd_cnt + wr_cnt;
        cen = 1'b0;
        fork
            rom0_read(a0, 1'b0);
            ram_access(a2, 1'b0, 8'h00, q);
            begin
                repeat (8) @(negedge clk);
                check(rd_cnt + wr_cnt, n0, "bus commands while cen low");
                check(32'(data_ok0), 32'd0, "slot 0 data_ok while cen low");
                cen = 1'b1;                      // slots pick up the pending requests
            end
        join
    end
    report_test("5 cen held low", c0, e0);

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
        $display("Testbench passed");
    else
        $display("Testbench failed");
    $finish;
end

endmodule

/* verif/jtframe_sdram_assertions.sv */
// bound assertions: external bus commands and the ram slot data_ok pulse
`timescale 1ns/100ps

module jtframe_sdram_assertions (
    input logic rst,
    input logic clk,
    input logic sd_rd,
    input logic sd_wr,
    input logic sd_rdy,
    input logic data_ok2
);

logic pending;      // command issued, sd_rdy not yet seen

always_ff @(posedge clk) begin
    if (rst)
        pending <= 1'b0;
    else if (sd_rd || sd_wr)
        pending <= 1'b1;
    else if (sd_rdy)
        pending <= 1'b0;
end

////////////////////
// bus
a_one_cmd: assert property (@(posedge clk) disable iff (rst) !(sd_rd && sd_wr))
    else $error("sd_rd and sd_wr high together");

a_no_overlap: assert property (@(posedge clk) disable iff (rst) pending |-> !(sd_rd || sd_wr))
    else $error("new command before sd_rdy");

a_reset_idle: assert property (@(posedge clk) rst |=> !(sd_rd || sd_wr))
    else $error("command strobe right after reset");

// ram slot strobe
a_ram_pulse: assert property (@(posedge clk) disable iff (rst) data_ok2 |=> !data_ok2)
    else $error("data_ok2 longer than one cycle");

endmodule

bind jtframe_sdram_sub jtframe_sdram_assertions u_assert (
    .rst      ( rst      ),
    .clk      ( clk      ),
    .sd_rd    ( sd_rd    ),
    .sd_wr    ( sd_wr    ),
    .sd_rdy   ( sd_rdy   ),
    .data_ok2 ( data_ok2 )
);

/* verilog.f */
+incdir+verilog
verilog/jtframe_sdram_slot_if.sv
verilog/jtframe_sdram_pkg.sv
verilog/jtframe_romrq.sv
verilog/jtframe_ram_rq.sv
verilog/jtframe_sdram_rq.sv
verilog/jtframe_sdram_arb.sv
verilog/jtframe_sdram_sub.sv
verif/jtframe_sdram_tb.sv
verif/jtframe_sdram_assertions.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sdram request testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module jtframe_sdram_tb -f verilog.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
